// File: hdl/cache_pkg.sv
package cache_pkg;

    // Address split: tag | index | offset
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    // Upper offset bits pick the 32-bit bank
    localparam int BANK_SEL_W = 2;

    // Line geometry
    localparam int SETS   = 1 << INDEX_W;
    localparam int BANKS  = 1 << BANK_SEL_W;
    localparam int LINE_W = BANKS * 32;

    // Memory side byte address
    localparam int ADDR_W = TAG_W + INDEX_W + OFFSET_W;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    // Main controller states
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOOKUP  = 3'd1,
        ST_MISS    = 3'd2,
        ST_REPLACE = 3'd3,
        ST_REFILL  = 3'd4
    } cache_state_e;

endpackage

// File: hdl/cache_way.sv
`timescale 1ns/1ps

module cache_way (
    input  logic                              clk,
    input  logic                              rst,

    // Read side, one cycle latency
    input  logic [cache_pkg::INDEX_W-1:0]     rd_index,
    input  logic [cache_pkg::TAG_W-1:0]       lookup_tag,

    // Write side
    input  logic [cache_pkg::INDEX_W-1:0]     wr_index,
    input  logic [cache_pkg::BANK_SEL_W-1:0]  wr_bank,
    input  logic [3:0]                        wr_strb,
    input  logic [31:0]                       wr_data,
    input  logic                              tag_we,
    input  logic                              fill_dirty,
    input  logic                              dirty_set,

    output logic                              hit,
    output logic [cache_pkg::TAG_W-1:0]       victim_tag,
    output logic                              victim_dirty,
    output logic [cache_pkg::LINE_W-1:0]      line
);

    logic [cache_pkg::TAG_W-1:0] tag_mem [cache_pkg::SETS];
    logic [31:0]                 bank_mem [cache_pkg::BANKS][cache_pkg::SETS];

    logic [cache_pkg::SETS-1:0]  valid_vec;
    logic [cache_pkg::SETS-1:0]  dirty_vec;

    logic [cache_pkg::TAG_W-1:0] tag_q;
    logic                        valid_q;
    logic                        dirty_q;

    // Tag store, written once per refill
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[wr_index] <= lookup_tag;
        end
        tag_q <= tag_mem[rd_index];
    end

    // Valid and dirty bits must start cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_vec <= '0;
            dirty_vec <= '0;
            valid_q   <= 1'b0;
            dirty_q   <= 1'b0;
        end
        else begin
            if (tag_we) begin
                valid_vec[wr_index] <= 1'b1;
                dirty_vec[wr_index] <= fill_dirty;
            end
            else if (dirty_set && hit) begin
                dirty_vec[wr_index] <= 1'b1;
            end
            valid_q <= valid_vec[rd_index];
            dirty_q <= dirty_vec[rd_index];
        end
    end

    // Data banks with byte enables, whole line read each cycle
    always_ff @(posedge clk) begin
        for (int b = 0; b < cache_pkg::BANKS; b++) begin
            for (int i = 0; i < 4; i++) begin
                if ((wr_bank == cache_pkg::BANK_SEL_W'(b)) && wr_strb[i]) begin
                    bank_mem[b][wr_index][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
            line[32*b +: 32] <= bank_mem[b][rd_index];
        end
    end

    assign hit          = valid_q && (tag_q == lookup_tag);
    assign victim_tag   = tag_q;
    // Only a valid line can need write-back
    assign victim_dirty = valid_q && dirty_q;

endmodule

// File: hdl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                              clk,
    input  logic                              rst,

    // CPU request
    input  logic                              valid,
    input  cache_pkg::cache_op_e              op,
    input  logic [cache_pkg::INDEX_W-1:0]     index,
    input  logic [cache_pkg::TAG_W-1:0]       tag,
    input  logic [cache_pkg::OFFSET_W-1:0]    offset,
    input  logic [3:0]                        wstrb,
    input  logic [31:0]                       wdata,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [31:0]                       rdata,

    // Results from the two ways
    input  logic                              hit0,
    input  logic                              hit1,
    input  logic [cache_pkg::LINE_W-1:0]      line0,
    input  logic [cache_pkg::LINE_W-1:0]      line1,
    input  logic [cache_pkg::TAG_W-1:0]       victim_tag0,
    input  logic [cache_pkg::TAG_W-1:0]       victim_tag1,
    input  logic                              victim_dirty0,
    input  logic                              victim_dirty1,

    // Shared way controls
    output logic [cache_pkg::INDEX_W-1:0]     rd_index,
    output logic [cache_pkg::TAG_W-1:0]       lookup_tag,
    output logic [cache_pkg::INDEX_W-1:0]     wr_index,
    output logic [cache_pkg::BANK_SEL_W-1:0]  wr_bank,
    output logic [31:0]                       wr_data,
    output logic                              fill_dirty,
    output logic                              dirty_set,

    // Per-way write enables
    output logic [3:0]                        bank_we0,
    output logic [3:0]                        bank_we1,
    output logic                              tag_we0,
    output logic                              tag_we1,

    // Memory refill and write-back
    output logic                              rd_req,
    output logic [cache_pkg::ADDR_W-1:0]      rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  logic                              ret_last,
    input  logic [31:0]                       ret_data,
    output logic                              wr_req,
    output logic [cache_pkg::ADDR_W-1:0]      wr_addr,
    output logic [cache_pkg::LINE_W-1:0]      wr_line,
    input  logic                              wr_rdy
);

    cache_pkg::cache_state_e state;
    cache_pkg::cache_state_e state_nxt;

    // Captured request
    cache_pkg::cache_op_e                op_reg;
    logic [cache_pkg::TAG_W-1:0]         tag_reg;
    logic [cache_pkg::INDEX_W-1:0]       index_reg;
    logic [cache_pkg::BANK_SEL_W-1:0]    bank_reg;
    logic [3:0]                          wstrb_reg;
    logic [31:0]                         wdata_reg;

    logic [15:0]                         lfsr;
    logic                                way_sel;
    logic [cache_pkg::BANK_SEL_W-1:0]    beat_cnt;

    logic                                hit;
    logic                                is_write;
    logic                                victim_dirty;
    logic [31:0]                         hit_word;
    logic [31:0]                         strb_mask;
    logic [31:0]                         fill_word;

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            op_reg    <= op;
            tag_reg   <= tag;
            index_reg <= index;
            bank_reg  <= offset[cache_pkg::OFFSET_W-1 -: cache_pkg::BANK_SEL_W];
            wstrb_reg <= wstrb;
            wdata_reg <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::ST_IDLE;
        end
        else begin
            state <= state_nxt;
        end
    end

    assign hit          = hit0 || hit1;
    assign is_write     = (op_reg == cache_pkg::OP_WRITE);
    assign victim_dirty = way_sel ? victim_dirty1 : victim_dirty0;

    always_comb begin
        state_nxt = state;
        unique case (state)
            cache_pkg::ST_IDLE: begin
                if (valid) begin
                    state_nxt = cache_pkg::ST_LOOKUP;
                end
            end
            cache_pkg::ST_LOOKUP: begin
                if (hit) begin
                    state_nxt = cache_pkg::ST_IDLE;
                end
                else begin
                    state_nxt = cache_pkg::ST_MISS;
                end
            end
            cache_pkg::ST_MISS: begin
                // Clean victim passes straight through
                if (!victim_dirty || wr_rdy) begin
                    state_nxt = cache_pkg::ST_REPLACE;
                end
            end
            cache_pkg::ST_REPLACE: begin
                if (rd_rdy) begin
                    state_nxt = cache_pkg::ST_REFILL;
                end
            end
            cache_pkg::ST_REFILL: begin
                if (ret_valid && ret_last) begin
                    state_nxt = cache_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = cache_pkg::ST_IDLE;
            end
        endcase
    end

    // Free-running x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 16'hace1;
        end
        else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // Victim way fixed for the whole miss
    always_ff @(posedge clk) begin
        if (rst) begin
            way_sel <= 1'b0;
        end
        else if ((state == cache_pkg::ST_LOOKUP) && !hit) begin
            way_sel <= lfsr[0];
        end
    end

    // Refill beat number, stalls across gaps
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end
        else if ((state == cache_pkg::ST_REFILL) && ret_valid) begin
            if (ret_last) begin
                beat_cnt <= '0;
            end
            else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    assign hit_word  = hit1 ? line1[32*bank_reg +: 32] : line0[32*bank_reg +: 32];
    assign strb_mask = {{8{wstrb_reg[3]}}, {8{wstrb_reg[2]}},
                        {8{wstrb_reg[1]}}, {8{wstrb_reg[0]}}};
    // Write miss data lands in its own beat
    assign fill_word = (is_write && (beat_cnt == bank_reg)) ?
                       ((ret_data & ~strb_mask) | (wdata_reg & strb_mask)) : ret_data;

    assign addr_ok = (state == cache_pkg::ST_IDLE);
    assign data_ok = ((state == cache_pkg::ST_LOOKUP) && (hit || is_write)) ||
                     ((state == cache_pkg::ST_REFILL) && !is_write && ret_valid &&
                      (beat_cnt == bank_reg));
    assign rdata   = (state == cache_pkg::ST_LOOKUP) ? hit_word : ret_data;

    assign rd_index   = (state == cache_pkg::ST_IDLE) ? index : index_reg;
    assign lookup_tag = tag_reg;
    assign wr_index   = index_reg;
    assign wr_bank    = (state == cache_pkg::ST_REFILL) ? beat_cnt : bank_reg;
    assign wr_data    = (state == cache_pkg::ST_REFILL) ? fill_word : wdata_reg;
    assign fill_dirty = is_write;
    assign dirty_set  = (state == cache_pkg::ST_LOOKUP) && hit && is_write;

    always_comb begin
        bank_we0 = 4'h0;
        bank_we1 = 4'h0;
        if ((state == cache_pkg::ST_LOOKUP) && is_write) begin
            if (hit0) begin
                bank_we0 = wstrb_reg;
            end
            if (hit1) begin
                bank_we1 = wstrb_reg;
            end
        end
        else if ((state == cache_pkg::ST_REFILL) && ret_valid) begin
            if (way_sel) begin
                bank_we1 = 4'hf;
            end
            else begin
                bank_we0 = 4'hf;
            end
        end
    end

    assign tag_we0 = (state == cache_pkg::ST_REFILL) && ret_valid && ret_last && !way_sel;
    assign tag_we1 = (state == cache_pkg::ST_REFILL) && ret_valid && ret_last && way_sel;

    assign rd_req  = (state == cache_pkg::ST_REPLACE);
    assign rd_addr = {tag_reg, index_reg, {cache_pkg::OFFSET_W{1'b0}}};

    assign wr_req  = (state == cache_pkg::ST_MISS) && victim_dirty;
    assign wr_addr = {(way_sel ? victim_tag1 : victim_tag0), index_reg,
                      {cache_pkg::OFFSET_W{1'b0}}};
    assign wr_line = way_sel ? line1 : line0;

endmodule

// File: hdl/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                              clk,
    input  logic                              rst,

    // CPU side
    input  logic                              valid,
    input  cache_pkg::cache_op_e              op,
    input  logic [cache_pkg::INDEX_W-1:0]     index,
    input  logic [cache_pkg::TAG_W-1:0]       tag,
    input  logic [cache_pkg::OFFSET_W-1:0]    offset,
    input  logic [3:0]                        wstrb,
    input  logic [31:0]                       wdata,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [31:0]                       rdata,

    // Memory side
    output logic                              rd_req,
    output logic [cache_pkg::ADDR_W-1:0]      rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  logic                              ret_last,
    input  logic [31:0]                       ret_data,
    output logic                              wr_req,
    output logic [cache_pkg::ADDR_W-1:0]      wr_addr,
    output logic [cache_pkg::LINE_W-1:0]      wr_data,
    input  logic                              wr_rdy
);

    logic [cache_pkg::INDEX_W-1:0]    rd_index;
    logic [cache_pkg::TAG_W-1:0]      lookup_tag;
    logic [cache_pkg::INDEX_W-1:0]    wr_index;
    logic [cache_pkg::BANK_SEL_W-1:0] wr_bank;
    logic [31:0]                      wr_word;
    logic                             fill_dirty;
    logic                             dirty_set;
    logic [3:0]                       bank_we0;
    logic [3:0]                       bank_we1;
    logic                             tag_we0;
    logic                             tag_we1;

    logic                             hit0;
    logic                             hit1;
    logic [cache_pkg::TAG_W-1:0]      victim_tag0;
    logic [cache_pkg::TAG_W-1:0]      victim_tag1;
    logic                             victim_dirty0;
    logic                             victim_dirty1;
    logic [cache_pkg::LINE_W-1:0]     line0;
    logic [cache_pkg::LINE_W-1:0]     line1;

    cache_way u_way0 (
        .clk          (clk),
        .rst          (rst),
        .rd_index     (rd_index),
        .lookup_tag   (lookup_tag),
        .wr_index     (wr_index),
        .wr_bank      (wr_bank),
        .wr_strb      (bank_we0),
        .wr_data      (wr_word),
        .tag_we       (tag_we0),
        .fill_dirty   (fill_dirty),
        .dirty_set    (dirty_set),
        .hit          (hit0),
        .victim_tag   (victim_tag0),
        .victim_dirty (victim_dirty0),
        .line         (line0)
    );

    cache_way u_way1 (
        .clk          (clk),
        .rst          (rst),
        .rd_index     (rd_index),
        .lookup_tag   (lookup_tag),
        .wr_index     (wr_index),
        .wr_bank      (wr_bank),
        .wr_strb      (bank_we1),
        .wr_data      (wr_word),
        .tag_we       (tag_we1),
        .fill_dirty   (fill_dirty),
        .dirty_set    (dirty_set),
        .hit          (hit1),
        .victim_tag   (victim_tag1),
        .victim_dirty (victim_dirty1),
        .line         (line1)
    );

    cache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .valid         (valid),
        .op            (op),
        .index         (index),
        .tag           (tag),
        .offset        (offset),
        .wstrb         (wstrb),
        .wdata         (wdata),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .hit0          (hit0),
        .hit1          (hit1),
        .line0         (line0),
        .line1         (line1),
        .victim_tag0   (victim_tag0),
        .victim_tag1   (victim_tag1),
        .victim_dirty0 (victim_dirty0),
        .victim_dirty1 (victim_dirty1),
        .rd_index      (rd_index),
        .lookup_tag    (lookup_tag),
        .wr_index      (wr_index),
        .wr_bank       (wr_bank),
        .wr_data       (wr_word),
        .fill_dirty    (fill_dirty),
        .dirty_set     (dirty_set),
        .bank_we0      (bank_we0),
        .bank_we1      (bank_we1),
        .tag_we0       (tag_we0),
        .tag_we1       (tag_we1),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .ret_last      (ret_last),
        .ret_data      (ret_data),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_line       (wr_data),
        .wr_rdy        (wr_rdy)
    );

endmodule

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd_req,
    input  logic [cache_pkg::ADDR_W-1:0]  rd_addr,
    output logic                          rd_rdy,
    output logic                          ret_valid,
    output logic                          ret_last,
    output logic [31:0]                   ret_data,
    input  logic                          wr_req,
    input  logic [cache_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [cache_pkg::LINE_W-1:0]  wr_data,
    output logic                          wr_rdy
);

    // Written-back words by byte address, others keep the fill pattern
    logic [31:0] mem [logic [31:0]];

    integer      seed = 27273;

    logic        rd_rdy_q    = 1'b0;
    logic        ret_valid_q = 1'b0;
    logic        ret_last_q  = 1'b0;
    logic [31:0] ret_data_q  = 32'h0;
    logic        wr_rdy_q    = 1'b0;

    logic        refilling = 1'b0;
    logic [2:0]  beat      = 3'd0;
    logic [2:0]  cur_beat;
    logic [31:0] fill_base = 32'h0;

    assign rd_rdy    = rd_rdy_q;
    assign ret_valid = ret_valid_q;
    assign ret_last  = ret_last_q;
    assign ret_data  = ret_data_q;
    assign wr_rdy    = wr_rdy_q;

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return init_word(addr);
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rd_rdy_q    <= 1'b0;
            ret_valid_q <= 1'b0;
            ret_last_q  <= 1'b0;
            ret_data_q  <= 32'h0;
            wr_rdy_q    <= 1'b0;
            refilling   <= 1'b0;
            beat        <= 3'd0;
        end
        else begin
            // Line write-back
            if (wr_req && wr_rdy_q) begin
                for (int b = 0; b < 4; b++) begin
                    mem[{wr_addr[31:4], b[1:0], 2'b00}] = wr_data[32*b +: 32];
                end
                wr_rdy_q <= 1'b0;
            end
            else if (wr_req) begin
                wr_rdy_q <= (($random(seed) & 1) != 0);
            end

            // Refill request
            if (rd_req && rd_rdy_q) begin
                rd_rdy_q  <= 1'b0;
                refilling <= 1'b1;
                beat      <= 3'd0;
                fill_base <= rd_addr;
            end
            else if (rd_req && !refilling) begin
                rd_rdy_q <= (($random(seed) & 1) != 0);
            end

            // Beats in bank order, random gaps
            if (refilling) begin
                if (ret_valid_q && ret_last_q) begin
                    ret_valid_q <= 1'b0;
                    ret_last_q  <= 1'b0;
                    refilling   <= 1'b0;
                end
                else begin
                    cur_beat = ret_valid_q ? beat + 3'd1 : beat;
                    beat <= cur_beat;
                    if (($random(seed) & 3) != 0) begin
                        ret_valid_q <= 1'b1;
                        ret_last_q  <= (cur_beat == 3'd3);
                        ret_data_q  <= read_word({fill_base[31:4], cur_beat[1:0], 2'b00});
                    end
                    else begin
                        ret_valid_q <= 1'b0;
                        ret_last_q  <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: testbench/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

    typedef struct packed {
        logic                            op;
        logic [cache_pkg::TAG_W-1:0]     tag;
        logic [cache_pkg::INDEX_W-1:0]   index;
        logic [cache_pkg::OFFSET_W-1:0]  offset;
        logic [3:0]                      wstrb;
        logic [31:0]                     wdata;
        logic                            one_cycle;
    } req_row_t;

    localparam int NUM_REQ     = 20;
    localparam int WATCHDOG_NS = NUM_REQ * 60 * 100;

    // op, tag, index, offset, wstrb, wdata, one-cycle data_ok expected
    localparam req_row_t REQ_TABLE [NUM_REQ] = '{
        // Cold miss, then the same word as a hit
        {cache_pkg::OP_READ,  20'h00012, 8'h20, 4'h4, 4'h0, 32'h0000_0000, 1'b0},
        {cache_pkg::OP_READ,  20'h00012, 8'h20, 4'h4, 4'h0, 32'h0000_0000, 1'b1},
        // Partial write hit
        {cache_pkg::OP_WRITE, 20'h00012, 8'h20, 4'h8, 4'h5, 32'h1122_3344, 1'b1},
        {cache_pkg::OP_READ,  20'h00012, 8'h20, 4'h8, 4'h0, 32'h0000_0000, 1'b1},
        // Write miss merged into the refill
        {cache_pkg::OP_WRITE, 20'h00078, 8'h30, 4'hc, 4'hc, 32'haabb_ccdd, 1'b1},
        {cache_pkg::OP_READ,  20'h00078, 8'h30, 4'hc, 4'h0, 32'h0000_0000, 1'b1},
        {cache_pkg::OP_READ,  20'h00078, 8'h30, 4'h0, 4'h0, 32'h0000_0000, 1'b1},
        {cache_pkg::OP_WRITE, 20'h00078, 8'h30, 4'hc, 4'h3, 32'h9988_7766, 1'b1},
        {cache_pkg::OP_READ,  20'h00078, 8'h30, 4'hc, 4'h0, 32'h0000_0000, 1'b1},
        // Three dirty tags in one set
        {cache_pkg::OP_WRITE, 20'h00012, 8'h10, 4'h0, 4'hf, 32'hdead_beef, 1'b1},
        {cache_pkg::OP_WRITE, 20'h00034, 8'h10, 4'h4, 4'h3, 32'h0000_cafe, 1'b1},
        {cache_pkg::OP_WRITE, 20'h00056, 8'h10, 4'h8, 4'hf, 32'h1234_5678, 1'b1},
        {cache_pkg::OP_READ,  20'h00012, 8'h10, 4'h0, 4'h0, 32'h0000_0000, 1'b0},
        {cache_pkg::OP_READ,  20'h00034, 8'h10, 4'h4, 4'h0, 32'h0000_0000, 1'b0},
        {cache_pkg::OP_READ,  20'h00056, 8'h10, 4'h8, 4'h0, 32'h0000_0000, 1'b0},
        {cache_pkg::OP_READ,  20'h00012, 8'h10, 4'hc, 4'h0, 32'h0000_0000, 1'b0},
        // Clean lines only
        {cache_pkg::OP_READ,  20'h0009a, 8'h40, 4'h0, 4'h0, 32'h0000_0000, 1'b0},
        {cache_pkg::OP_READ,  20'h000bc, 8'h40, 4'h4, 4'h0, 32'h0000_0000, 1'b0},
        {cache_pkg::OP_READ,  20'h000de, 8'h40, 4'h8, 4'h0, 32'h0000_0000, 1'b0},
        {cache_pkg::OP_READ,  20'h0009a, 8'h40, 4'h0, 4'h0, 32'h0000_0000, 1'b0}
    };

    logic                            clk    = 1'b0;
    logic                            rst    = 1'b1;
    logic                            valid  = 1'b0;
    cache_pkg::cache_op_e            op     = cache_pkg::OP_READ;
    logic [cache_pkg::INDEX_W-1:0]   index  = '0;
    logic [cache_pkg::TAG_W-1:0]     tag    = '0;
    logic [cache_pkg::OFFSET_W-1:0]  offset = '0;
    logic [3:0]                      wstrb  = 4'h0;
    logic [31:0]                     wdata  = 32'h0;

    logic                            addr_ok;
    logic                            data_ok;
    logic [31:0]                     rdata;
    logic                            rd_req;
    logic [cache_pkg::ADDR_W-1:0]    rd_addr;
    logic                            rd_rdy;
    logic                            ret_valid;
    logic                            ret_last;
    logic [31:0]                     ret_data;
    logic                            wr_req;
    logic [cache_pkg::ADDR_W-1:0]    wr_addr;
    logic [cache_pkg::LINE_W-1:0]    wr_data;
    logic                            wr_rdy;

    int          err_count   = 0;
    int          check_count = 0;
    logic [31:0] shadow [logic [31:0]];
    bit          written [logic [27:0]];
    // Line address of the request in flight
    logic [31:0] line_addr   = 32'h0;

    always #50 clk = ~clk;

    cache_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    // Same fill pattern as the memory model
    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return init_word(addr);
    endfunction

    task automatic write_shadow(input logic [31:0] addr, input logic [3:0] strb,
                                input logic [31:0] data);
        logic [31:0] word;
        word = shadow_word(addr);
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                word[8*k +: 8] = data[8*k +: 8];
            end
        end
        shadow[addr] = word;
        written[addr[31:4]] = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("Error %s expected 0x%0h actual 0x%0h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_write_back();
        check_count++;
        assert (written.exists(wr_addr[31:4])) else begin
            $display("Write-back of line 0x%h, which the CPU never wrote", wr_addr);
            err_count++;
        end
        // Victim shares the index of the request, offset zero
        check_value("wr_addr[11:0]", 32'(wr_addr[11:0]), 32'(line_addr[11:0]));
        for (int b = 0; b < 4; b++) begin
            check_value($sformatf("wr_data[%0d] at 0x%h", b, wr_addr), wr_data[32*b +: 32],
                        shadow_word({wr_addr[31:4], b[1:0], 2'b00}));
        end
    endtask

    task automatic run_request(input int n);
        req_row_t    row;
        logic [31:0] addr;
        logic [31:0] expected;
        int          cycles;
        row  = REQ_TABLE[n];
        addr = {row.tag, row.index, row.offset[3:2], 2'b00};
        @(posedge clk);
        valid  <= 1'b1;
        op     <= cache_pkg::cache_op_e'(row.op);
        tag    <= row.tag;
        index  <= row.index;
        offset <= row.offset;
        wstrb  <= row.wstrb;
        wdata  <= row.wdata;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        valid <= 1'b0;
        line_addr = {row.tag, row.index, 4'h0};
        if (row.op == cache_pkg::OP_WRITE) begin
            write_shadow(addr, row.wstrb, row.wdata);
        end
        expected = shadow_word(addr);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!data_ok);
        if (row.op == cache_pkg::OP_READ) begin
            check_value("rdata", rdata, expected);
        end
        if (row.one_cycle) begin
            check_value("data_ok latency", 32'(cycles), 32'd1);
        end
    endtask

    // Refills fetch the requested line, write-backs carry the current line
    always @(posedge clk) begin
        if (!rst && rd_req && rd_rdy) begin
            check_value("rd_addr", rd_addr, line_addr);
        end
        if (!rst && wr_req && wr_rdy) begin
            check_write_back();
        end
    end

    initial begin
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("addr_ok", 32'(addr_ok), 32'd1);
        check_value("data_ok", 32'(data_ok), 32'd0);
        check_value("rd_req", 32'(rd_req), 32'd0);
        check_value("wr_req", 32'(wr_req), 32'd0);
        for (int n = 0; n < NUM_REQ; n++) begin
            run_request(n);
        end
        while (!addr_ok) begin
            @(posedge clk);
        end
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end
        else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the request table did not complete", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: verilog.f
hdl/cache_pkg.sv
hdl/cache_way.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
testbench/tb_mem_model.sv
testbench/tb_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_cache -o sim_cache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
